//--- Makefile
# Verilator build and run of the gmc testbench
SIM = obj_dir/Vgmc_tb

all: run

$(SIM): gmc.f include/gmc_params.svh verilog/*.sv tests/*.sv
	verilator --binary --timing --timescale 1ns/10ps -Wno-fatal \
		--top-module gmc_tb -f gmc.f -o Vgmc_tb

# pass or fail comes from the log, not from the exit code
run: $(SIM)
	$(SIM) | tee sim.log
	grep -q "Simulation PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean

//--- gmc.f
+incdir+include
verilog/gmc_axi_pkg.sv
verilog/gmc_cache_pkg.sv
verilog/gmc_fill_engine.sv
verilog/gmc_aw_queue.sv
verilog/gmc_writeback_engine.sv
verilog/gmc_axi_controllers.sv
tests/gmc_clk_gen.sv
tests/gmc_tb.sv

//--- include/gmc_params.svh
`ifndef GMC_PARAMS_SVH
`define GMC_PARAMS_SVH

// one bus word is one cache word
`define GMC_DATA_W 32
`define GMC_ADDR_W 32
// log2 of beats per line
`define GMC_BURST_W 3
`define GMC_LINE_ADDR_W 16
// log2 of queued write-back bursts
`define GMC_WB_BURSTS_W 1

`define GMC_LINE_WORDS (1 << `GMC_BURST_W)
// byte offset bits within a line of 4-byte words
`define GMC_LINE_OFS_W (`GMC_BURST_W + 2)
`define GMC_WB_BURSTS (1 << `GMC_WB_BURSTS_W)
`define GMC_WB_FIFO_W (`GMC_BURST_W + `GMC_WB_BURSTS_W)
`define GMC_WB_FIFO_DEPTH (1 << `GMC_WB_FIFO_W)

`endif

//--- tests/gmc_clk_gen.sv
`timescale 1ns/10ps

module gmc_clk_gen #(
   parameter int PERIOD = 100
) (
   output logic clk_o
);

   initial begin
      clk_o = 1'b0;
      forever #(PERIOD / 2) clk_o = ~clk_o;
   end

endmodule

//--- tests/gmc_tb.sv
`timescale 1ns/10ps
`include "gmc_params.svh"

module gmc_tb;

   localparam int TIMEOUT = 3000;  // cycles per wait

   logic clk;
   logic nrst;
   logic fill_go_i;
   logic wb_go_i;
   gmc_cache_pkg::line_addr_t fill_line_i;
   gmc_cache_pkg::line_addr_t wb_line_i;
   logic fill_ack_i = 1'b0;
   logic wb_ack_i = 1'b0;
   logic wb_data_valid_i = 1'b0;
   gmc_axi_pkg::axi_data_t wb_data_i = '0;
   logic arready_i = 1'b0;
   logic rvalid_i = 1'b0;
   logic rlast_i = 1'b0;
   gmc_axi_pkg::axi_data_t rdata_i = '0;
   logic awready_i = 1'b0;
   logic wready_i = 1'b0;
   logic bvalid_i = 1'b0;
   logic fill_free_o, wb_free_o, wb_done_o, fill_rqst_o, fill_valid_o, wb_rqst_o;
   logic arvalid_o, rready_o, awvalid_o, wvalid_o, wlast_o, bready_o;
   gmc_cache_pkg::line_addr_t fill_line_o, wb_line_o;
   gmc_axi_pkg::axi_data_t fill_data_o, wdata_o;
   gmc_axi_pkg::axi_addr_t araddr_o, awaddr_o;

   int seed = 76;
   logic stress = 1'b0;  // random readies, valids and gaps
   logic aw_hold = 1'b0;  // memory stalls AW until the queue fills
   logic aw_fire = 1'b0;
   logic wb_free_seen = 1'b0;
   logic wb_done_seen = 1'b0;
   int err_cnt = 0;
   int chk_cnt = 0;
   int err_mark = 0;
   int test_cnt = 0;
   int n_push = 0;
   int n_pop = 0;
   int n_done = 0;
   int wb_issued = 0;
   int r_left = 0;
   int b_pend = 0;
   int wb_left = 0;
   int fv_run = 0;
   gmc_axi_pkg::axi_addr_t r_addr = '0;
   gmc_axi_pkg::axi_addr_t wb_addr = '0;
   gmc_axi_pkg::axi_data_t exp_fill[$], got_fill[$];  // araddr_o, then 8 words
   gmc_axi_pkg::axi_addr_t exp_aw[$], got_aw[$];
   logic [32:0] exp_w[$], got_w[$];  // {wlast, data}

   gmc_clk_gen u_clk (.clk_o(clk));

   gmc_axi_controllers u_dut (.*);

   // memory content as a fixed scramble of the byte address
   function automatic gmc_axi_pkg::axi_data_t mem_word(input gmc_axi_pkg::axi_addr_t addr);
      return (addr * 32'h9e37_79b1) ^ {addr[15:0], addr[31:16]} ^ 32'h5a5a_0f0f;
   endfunction

   function automatic logic rnd_ready();
      if (!stress) begin
         return 1'b1;
      end
      return ($random(seed) % 4) != 0;
   endfunction

   function automatic logic is_settled(input string what);
      if (what == "fill") begin
         return fill_free_o && exp_fill.size() == 0;
      end else if (what == "wb_free_o") begin
         return wb_free_o;
      end
      return n_done >= wb_issued && exp_aw.size() == 0 && exp_w.size() == 0;
   endfunction

   task automatic check_equal(input logic [63:0] got, input logic [63:0] exp,
                              input string what);
      chk_cnt++;
      if (got !== exp) begin
         err_cnt++;
         $display("FAILED at %0d ns: %s, got %0h, expected %0h", $time, what, got, exp);
      end
   endtask

   task automatic stop_on_timeout(input string what);
      $display("timeout while waiting for %s, gave up after %0d cycles", what, TIMEOUT);
      $display("Simulation FAILED");
      $finish;
   endtask

   task automatic wait_for(input string what);
      int n;
      n = 0;
      while (!is_settled(what) && n < TIMEOUT) begin
         @(negedge clk);
         n++;
      end
      if (n >= TIMEOUT) begin
         stop_on_timeout(what);
      end
   endtask

   task automatic set_stress(input logic on);
      @(posedge clk);
      stress = on;
      @(negedge clk);
   endtask

   task automatic run_fill();
      gmc_cache_pkg::line_addr_t line;
      gmc_axi_pkg::axi_addr_t base;
      @(posedge clk);
      line = gmc_cache_pkg::line_addr_t'($random(seed));
      base = gmc_axi_pkg::axi_addr_t'(line) * 32;
      @(negedge clk);
      wait_for("fill");
      fill_go_i = 1'b1;
      fill_line_i = line;
      exp_fill.push_back(base);
      for (int i = 0; i < `GMC_LINE_WORDS; i++) begin
         exp_fill.push_back(mem_word(base + 4 * i));
      end
      @(negedge clk);
      fill_go_i = 1'b0;
      wait_for("fill");
   endtask

   task automatic run_writebacks(input int count);
      gmc_cache_pkg::line_addr_t line;
      gmc_axi_pkg::axi_addr_t base;
      for (int k = 0; k < count; k++) begin
         @(posedge clk);
         line = gmc_cache_pkg::line_addr_t'($random(seed));
         base = gmc_axi_pkg::axi_addr_t'(line) * 32;
         @(negedge clk);
         wait_for("wb_free_o");
         wb_go_i = 1'b1;
         wb_line_i = line;
         exp_aw.push_back(base);
         for (int i = 0; i < `GMC_LINE_WORDS; i++) begin
            exp_w.push_back({i == `GMC_LINE_WORDS - 1, mem_word(base + 4 * i)});
         end
         @(negedge clk);
         wb_go_i = 1'b0;
         wb_issued++;
      end
      wait_for("write responses");
      repeat (2) @(negedge clk);  // room for a stray extra pulse
      check_equal(n_done, wb_issued, "wb_done_o pulses against issued write-backs");
   endtask

   task automatic end_test(input string name);
      repeat (2) @(negedge clk);
      check_equal(exp_fill.size() + got_fill.size() + exp_aw.size() + got_aw.size() +
                  exp_w.size() + got_w.size(), 0, "transfers left unmatched");
      test_cnt++;
      if (err_cnt == err_mark) begin
         $display("test %0d %s: ok", test_cnt, name);
      end else begin
         $display("test %0d %s: %0d errors", test_cnt, name, err_cnt - err_mark);
      end
      err_mark = err_cnt;
   endtask

   // AXI memory model decides each transfer at the falling edge before it happens
   always @(negedge clk) begin
      rvalid_i = (r_left != 0) && rnd_ready();
      rdata_i = mem_word(r_addr);
      rlast_i = (r_left == 1);
      if (rvalid_i && rready_o) begin
         r_addr += 4;
         r_left--;
      end
      arready_i = arvalid_o && rnd_ready();
      if (arvalid_o && arready_i) begin
         got_fill.push_back(araddr_o);
         r_addr = araddr_o;
         r_left = `GMC_LINE_WORDS;
      end
      bvalid_i = (b_pend != 0) && rnd_ready();
      if (bvalid_i && bready_o) begin
         b_pend--;
      end
      wb_done_seen = wb_done_o;
      wb_free_seen = wb_free_o;
      if (aw_hold && n_push - n_pop == `GMC_WB_BURSTS && !wb_rqst_o) begin
         aw_hold = 1'b0;  // queue full while the engine is idle
      end
      awready_i = rnd_ready() && !aw_hold;
      aw_fire = awvalid_o && awready_i;
      if (aw_fire) begin
         got_aw.push_back(awaddr_o);
      end
      wready_i = rnd_ready();
      if (wvalid_o && wready_i) begin
         got_w.push_back({wlast_o, wdata_o});
         b_pend += wlast_o;  // response once the burst is complete
      end
   end

   // cache side
   always @(negedge clk) begin
      if (fill_ack_i) begin
         check_equal(fill_valid_o, 1'b1, "fill_valid_o the cycle after fill_ack_i");
      end
      fill_ack_i = fill_rqst_o && rnd_ready();
      if (fill_ack_i) begin
         check_equal(fill_line_o, fill_line_i, "fill_line_o at the cache request");
      end
      if (fill_valid_o) begin
         got_fill.push_back(fill_data_o);
         fv_run++;
      end else if (fv_run != 0) begin
         check_equal(fv_run, `GMC_LINE_WORDS, "fill_valid_o run length");
         fv_run = 0;
      end
      wb_data_valid_i = (wb_left != 0) && rnd_ready();
      wb_data_i = mem_word(wb_addr);
      if (wb_data_valid_i) begin
         wb_addr += 4;
         wb_left--;
      end
      wb_ack_i = wb_rqst_o && (wb_left == 0) && rnd_ready();
      if (wb_ack_i) begin
         wb_addr = gmc_axi_pkg::axi_addr_t'(wb_line_o) * 32;
         wb_left = `GMC_LINE_WORDS;
      end
   end

   // compare the transfers captured at the falling edge with the expected queues
   always @(posedge clk) begin
      if (!nrst) begin
         if (wb_free_seen) begin
            check_equal(n_push - n_pop < `GMC_WB_BURSTS, 1'b1, "wb_free_o with full AW queue");
         end
         if (wb_go_i && wb_free_seen) begin
            n_push++;
         end
         if (aw_fire) begin
            n_pop++;
         end
         if (wb_done_seen) begin
            check_equal(n_done < n_push, 1'b1, "wb_done_o pulse without open write-back");
            n_done++;
         end
         while (got_fill.size() != 0 && exp_fill.size() != 0) begin
            check_equal(got_fill.pop_front(), exp_fill.pop_front(), "fill address or word");
         end
         while (got_aw.size() != 0 && exp_aw.size() != 0) begin
            check_equal(got_aw.pop_front(), exp_aw.pop_front(), "awaddr_o");
         end
         while (got_w.size() != 0 && exp_w.size() != 0) begin
            check_equal(got_w.pop_front(), exp_w.pop_front(), "wlast_o and wdata_o");
         end
      end
   end

   initial begin
      nrst = 1'b1;
      fill_go_i = 1'b0;
      wb_go_i = 1'b0;
      fill_line_i = '0;
      wb_line_i = '0;
      repeat (2) @(negedge clk);
      nrst = 1'b0;
      check_equal({arvalid_o, rready_o, awvalid_o, wvalid_o, bready_o, fill_rqst_o,
                   fill_valid_o, wb_rqst_o, wb_done_o, fill_free_o, wb_free_o},
                  11'b000_0000_0011, "control outputs after reset");
      end_test("reset values");
      run_fill();
      end_test("fill");
      set_stress(1'b1);
      repeat (2) run_fill();
      end_test("fill under back-pressure");
      set_stress(1'b0);
      run_writebacks(1);
      end_test("write-back");
      set_stress(1'b1);
      aw_hold = 1'b1;
      run_writebacks(3);
      end_test("queued write-backs");
      $display("tests %0d, checks %0d, errors %0d", test_cnt, chk_cnt, err_cnt);
      if (err_cnt == 0) begin
         $display("Simulation PASSED");
      end else begin
         $display("Simulation FAILED");
      end
      $finish;
   end

endmodule

//--- verilog/gmc_aw_queue.sv
`timescale 1ns/10ps
`include "gmc_params.svh"

module gmc_aw_queue (
   input  logic                      clk,
   input  logic                      nrst,
   input  logic                      push_i,
   input  gmc_cache_pkg::line_addr_t push_line_i,
   output logic                      full_o,
   output gmc_axi_pkg::axi_addr_t    awaddr_o,
   output logic                      awvalid_o,
   input  logic                      awready_i
);

   gmc_axi_pkg::axi_addr_t addr_mem [`GMC_WB_BURSTS];
   logic [`GMC_WB_BURSTS_W-1:0] wr_ptr;
   logic [`GMC_WB_BURSTS_W-1:0] rd_ptr;
   logic [`GMC_WB_BURSTS_W-1:0] wr_ptr_nx;
   logic [`GMC_WB_BURSTS_W-1:0] rd_ptr_nx;
   logic nempty;
   logic nempty_nx;
   logic full_nx;
   logic push;
   logic pop;

   assign push = push_i && !full_o;
   assign pop = awvalid_o && awready_i;
   assign awvalid_o = nempty;
   assign awaddr_o = addr_mem[rd_ptr];

   always_ff @(posedge clk) begin
      if (push) begin
         addr_mem[wr_ptr] <= gmc_axi_pkg::axi_addr_t'(push_line_i) << `GMC_LINE_OFS_W;
      end
   end

   always_comb begin
      wr_ptr_nx = push ? wr_ptr + 1'b1 : wr_ptr;
      rd_ptr_nx = pop ? rd_ptr + 1'b1 : rd_ptr;
      full_nx = full_o;
      nempty_nx = nempty;
      if (push && !pop) begin
         nempty_nx = 1'b1;
         full_nx = (wr_ptr_nx == rd_ptr);  // caught up with the read side
      end else if (pop && !push) begin
         full_nx = 1'b0;
         nempty_nx = (rd_ptr_nx != wr_ptr);
      end
   end

   always_ff @(posedge clk) begin
      if (nrst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         full_o <= 1'b0;
         nempty <= 1'b0;
      end else begin
         wr_ptr <= wr_ptr_nx;
         rd_ptr <= rd_ptr_nx;
         full_o <= full_nx;
         nempty <= nempty_nx;
      end
   end

endmodule

//--- verilog/gmc_axi_controllers.sv
`timescale 1ns/10ps
`include "gmc_params.svh"

module gmc_axi_controllers (
   input  logic                      clk,
   input  logic                      nrst,
   // tag side
   input  logic                      fill_go_i,
   input  gmc_cache_pkg::line_addr_t fill_line_i,
   output logic                      fill_free_o,
   input  logic                      wb_go_i,
   input  gmc_cache_pkg::line_addr_t wb_line_i,
   output logic                      wb_free_o,
   output logic                      wb_done_o,
   // cache side
   output logic                      fill_rqst_o,
   output gmc_cache_pkg::line_addr_t fill_line_o,
   input  logic                      fill_ack_i,
   output gmc_axi_pkg::axi_data_t    fill_data_o,
   output logic                      fill_valid_o,
   output logic                      wb_rqst_o,
   output gmc_cache_pkg::line_addr_t wb_line_o,
   input  logic                      wb_ack_i,
   input  gmc_axi_pkg::axi_data_t    wb_data_i,
   input  logic                      wb_data_valid_i,
   // AXI4 memory side
   output gmc_axi_pkg::axi_addr_t    araddr_o,
   output logic                      arvalid_o,
   input  logic                      arready_i,
   input  gmc_axi_pkg::axi_data_t    rdata_i,
   input  logic                      rvalid_i,
   input  logic                      rlast_i,
   output logic                      rready_o,
   output gmc_axi_pkg::axi_addr_t    awaddr_o,
   output logic                      awvalid_o,
   input  logic                      awready_i,
   output gmc_axi_pkg::axi_data_t    wdata_o,
   output logic                      wvalid_o,
   output logic                      wlast_o,
   input  logic                      wready_i,
   input  logic                      bvalid_i,
   output logic                      bready_o
);

   logic aw_full;
   logic aw_push;

   // only a go that the write-back engine accepts enters the queue
   assign aw_push = wb_go_i && wb_free_o;

   gmc_fill_engine u_fill (
      .clk, .nrst, .fill_go_i, .fill_line_i, .fill_free_o,
      .araddr_o, .arvalid_o, .arready_i, .rdata_i, .rvalid_i, .rlast_i, .rready_o,
      .fill_rqst_o, .fill_line_o, .fill_ack_i, .fill_data_o, .fill_valid_o
   );

   // write-back addresses queue here until AW accepts them
   gmc_aw_queue u_aw (
      .clk, .nrst, .push_i(aw_push), .push_line_i(wb_line_i), .full_o(aw_full),
      .awaddr_o, .awvalid_o, .awready_i
   );

   gmc_writeback_engine u_wb (
      .clk, .nrst, .wb_go_i, .wb_line_i, .wb_free_o, .aw_full_i(aw_full),
      .wb_rqst_o, .wb_line_o, .wb_ack_i, .wb_data_i, .wb_data_valid_i,
      .wdata_o, .wvalid_o, .wlast_o, .wready_i, .bvalid_i, .bready_o, .wb_done_o
   );

endmodule

//--- verilog/gmc_axi_pkg.sv
`include "gmc_params.svh"

package gmc_axi_pkg;

   // byte address on the AR and AW channels
   typedef logic [`GMC_ADDR_W-1:0] axi_addr_t;

   // one beat on R or W
   typedef logic [`GMC_DATA_W-1:0] axi_data_t;

endpackage

//--- verilog/gmc_cache_pkg.sv
`include "gmc_params.svh"

package gmc_cache_pkg;

   typedef logic [`GMC_LINE_ADDR_W-1:0] line_addr_t;
   typedef logic [`GMC_BURST_W-1:0] beat_idx_t;

   // one extra bit so a full FIFO counts as 16
   typedef logic [`GMC_WB_FIFO_W:0] wb_level_t;

   typedef enum logic [1:0] {
      fill_idle,
      fill_send_addr,
      fill_get_data,
      fill_to_cache
   } fill_state_e;

   typedef enum logic [1:0] {
      wb_idle,
      wb_fill_fifo,
      wb_wait_room
   } wb_state_e;

endpackage

//--- verilog/gmc_fill_engine.sv
`timescale 1ns/10ps
`include "gmc_params.svh"

module gmc_fill_engine (
   input  logic                      clk,
   input  logic                      nrst,
   input  logic                      fill_go_i,
   input  gmc_cache_pkg::line_addr_t fill_line_i,
   output logic                      fill_free_o,
   output gmc_axi_pkg::axi_addr_t    araddr_o,
   output logic                      arvalid_o,
   input  logic                      arready_i,
   input  gmc_axi_pkg::axi_data_t    rdata_i,
   input  logic                      rvalid_i,
   input  logic                      rlast_i,
   output logic                      rready_o,
   output logic                      fill_rqst_o,
   output gmc_cache_pkg::line_addr_t fill_line_o,
   input  logic                      fill_ack_i,
   output gmc_axi_pkg::axi_data_t    fill_data_o,
   output logic                      fill_valid_o
);

   gmc_cache_pkg::fill_state_e state;
   gmc_axi_pkg::axi_data_t line_buf [`GMC_LINE_WORDS];
   gmc_cache_pkg::beat_idx_t wr_idx;
   gmc_cache_pkg::beat_idx_t rd_idx;
   logic go_take;
   logic beat_in;

   assign go_take = fill_go_i && fill_free_o;
   assign rready_o = (state == gmc_cache_pkg::fill_get_data);
   assign beat_in = rvalid_i && rready_o;
   assign fill_data_o = line_buf[rd_idx];

   // line index to byte address
   always_ff @(posedge clk) begin
      if (go_take) begin
         araddr_o <= gmc_axi_pkg::axi_addr_t'(fill_line_i) << `GMC_LINE_OFS_W;
         fill_line_o <= fill_line_i;
      end
   end

   always_ff @(posedge clk) begin
      if (beat_in) begin
         line_buf[wr_idx] <= rdata_i;
      end
   end

   always_ff @(posedge clk) begin
      if (nrst) begin
         state <= gmc_cache_pkg::fill_idle;
         fill_free_o <= 1'b1;
         arvalid_o <= 1'b0;
         fill_rqst_o <= 1'b0;
         fill_valid_o <= 1'b0;
         wr_idx <= '0;
         rd_idx <= '0;
      end else begin
         case (state)
            gmc_cache_pkg::fill_idle: begin
               if (go_take) begin  // miss from the tag side
                  state <= gmc_cache_pkg::fill_send_addr;
                  fill_free_o <= 1'b0;
                  arvalid_o <= 1'b1;
               end
            end
            gmc_cache_pkg::fill_send_addr: begin
               if (arready_i) begin
                  arvalid_o <= 1'b0;
                  state <= gmc_cache_pkg::fill_get_data;
               end
            end
            gmc_cache_pkg::fill_get_data: begin
               if (beat_in) begin
                  wr_idx <= rlast_i ? '0 : wr_idx + 1'b1;
                  if (rlast_i) begin
                     state <= gmc_cache_pkg::fill_to_cache;
                     fill_rqst_o <= 1'b1;
                  end
               end
            end
            gmc_cache_pkg::fill_to_cache: begin
               if (fill_rqst_o && fill_ack_i) begin
                  fill_rqst_o <= 1'b0;
                  fill_valid_o <= 1'b1;
               end
               if (fill_valid_o) begin
                  rd_idx <= rd_idx + 1'b1;
                  if (rd_idx == '1) begin  // last word to cache
                     fill_valid_o <= 1'b0;
                     fill_free_o <= 1'b1;
                     state <= gmc_cache_pkg::fill_idle;
                  end
               end
            end
            default: state <= gmc_cache_pkg::fill_idle;
         endcase
      end
   end

endmodule

//--- verilog/gmc_writeback_engine.sv
`timescale 1ns/10ps
`include "gmc_params.svh"

module gmc_writeback_engine (
   input  logic                      clk,
   input  logic                      nrst,
   input  logic                      wb_go_i,
   input  gmc_cache_pkg::line_addr_t wb_line_i,
   output logic                      wb_free_o,
   input  logic                      aw_full_i,
   output logic                      wb_rqst_o,
   output gmc_cache_pkg::line_addr_t wb_line_o,
   input  logic                      wb_ack_i,
   input  gmc_axi_pkg::axi_data_t    wb_data_i,
   input  logic                      wb_data_valid_i,
   output gmc_axi_pkg::axi_data_t    wdata_o,
   output logic                      wvalid_o,
   output logic                      wlast_o,
   input  logic                      wready_i,
   input  logic                      bvalid_i,
   output logic                      bready_o,
   output logic                      wb_done_o
);

   gmc_cache_pkg::wb_state_e state;
   gmc_axi_pkg::axi_data_t data_fifo [`GMC_WB_FIFO_DEPTH];
   logic [`GMC_WB_FIFO_W-1:0] wr_ptr;
   logic [`GMC_WB_FIFO_W-1:0] rd_ptr;
   gmc_cache_pkg::wb_level_t level;
   gmc_cache_pkg::wb_level_t level_nx;
   gmc_cache_pkg::wb_level_t level_ack;
   gmc_cache_pkg::wb_level_t level_ack_nx;
   gmc_cache_pkg::beat_idx_t beat_cnt;
   logic [`GMC_WB_FIFO_W-1:0] out_cnt;  // bursts waiting for B
   logic go_take;
   logic ack_take;
   logic pop;
   logic b_take;
   logic room;

   assign go_take = wb_go_i && wb_free_o;
   assign ack_take = wb_ack_i && wb_rqst_o;
   assign wvalid_o = (level != '0);
   assign wdata_o = data_fifo[rd_ptr];
   assign wlast_o = (beat_cnt == '1);
   assign pop = wvalid_o && wready_i;
   assign bready_o = (out_cnt != '0);
   assign b_take = bvalid_i && bready_o;

   // level_ack books a whole line at ack time
   always_comb begin
      level_nx = level;
      level_ack_nx = level_ack;
      if (wb_data_valid_i) begin
         level_nx = level_nx + 1'b1;
      end
      if (pop) begin
         level_nx = level_nx - 1'b1;
         level_ack_nx = level_ack_nx - 1'b1;
      end
      if (ack_take) begin
         level_ack_nx = level_ack_nx + gmc_cache_pkg::wb_level_t'(`GMC_LINE_WORDS);
      end
   end

   assign room = level_ack_nx <=
                 gmc_cache_pkg::wb_level_t'(`GMC_WB_FIFO_DEPTH - `GMC_LINE_WORDS);

   always_ff @(posedge clk) begin
      if (wb_data_valid_i) begin
         data_fifo[wr_ptr] <= wb_data_i;
      end
      if (go_take) begin
         wb_line_o <= wb_line_i;
      end
   end

   always_ff @(posedge clk) begin
      if (nrst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         level <= '0;
         level_ack <= '0;
         beat_cnt <= '0;
         out_cnt <= '0;
         wb_done_o <= 1'b0;
      end else begin
         wr_ptr <= wb_data_valid_i ? wr_ptr + 1'b1 : wr_ptr;
         rd_ptr <= pop ? rd_ptr + 1'b1 : rd_ptr;
         beat_cnt <= pop ? beat_cnt + 1'b1 : beat_cnt;
         level <= level_nx;
         level_ack <= level_ack_nx;
         if (go_take && !b_take) begin
            out_cnt <= out_cnt + 1'b1;
         end else if (b_take && !go_take) begin
            out_cnt <= out_cnt - 1'b1;
         end
         wb_done_o <= b_take;
      end
   end

   always_ff @(posedge clk) begin
      if (nrst) begin
         state <= gmc_cache_pkg::wb_idle;
         wb_free_o <= 1'b1;
         wb_rqst_o <= 1'b0;
      end else begin
         case (state)
            gmc_cache_pkg::wb_idle: begin
               wb_free_o <= !aw_full_i;
               if (go_take) begin  // eviction from the tag side
                  state <= gmc_cache_pkg::wb_fill_fifo;
                  wb_rqst_o <= 1'b1;
                  wb_free_o <= 1'b0;
               end
            end
            gmc_cache_pkg::wb_fill_fifo: begin
               if (ack_take) begin
                  wb_rqst_o <= 1'b0;
                  if (room) begin
                     state <= gmc_cache_pkg::wb_idle;
                     wb_free_o <= !aw_full_i;
                  end else begin
                     state <= gmc_cache_pkg::wb_wait_room;
                  end
               end
            end
            gmc_cache_pkg::wb_wait_room: begin
               if (room) begin  // W channel drained enough
                  state <= gmc_cache_pkg::wb_idle;
                  wb_free_o <= !aw_full_i;
               end
            end
            default: state <= gmc_cache_pkg::wb_idle;
         endcase
      end
   end

endmodule
